// ==== Makefile ====
# Verilator build and run of the vector decode unit testbench

SRCS := $(filter-out +%,$(shell cat all.f)) design/vec_defines.svh

run: obj_dir/Vtb_vec_decode
	@out="$$(./$<)"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

# Rebuilt only when the file list or a source changes
obj_dir/V%: all.f $(SRCS)
	verilator --binary --assert -Wno-fatal -j 0 -f all.f --top-module $*

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== all.f ====
+incdir+design
design/vec_pkg.sv
design/vec_decode_if.sv
design/vec_instr_decode.sv
design/vec_evl_calc.sv
design/vec_uop_seq.sv
design/vec_decode_top.sv
dv/tb_vec_decode.sv

// ==== design/vec_decode_if.sv ====
// Decoded instruction bundle shared by the decoder, length calculator and sequencer
`timescale 1ns/1ps
`include "vec_defines.svh"

interface vec_decode_if (
    input logic CLK,
    input logic nRST
);

    // Classification and vset* results
    vec_pkg::vec_moc_t  moc;
    logic               is_cfg;
    logic               illegal;
    vec_pkg::vec_vset_t vset_type;
    logic [10:0]        vtype_imm;
    logic               keep_vl;

    // Memory access shape
    logic             mem_rd;
    logic             mem_wr;
    logic             unit_stride;
    logic             strided;
    logic             indexed;
    logic             mask_ldst;
    logic             whole_reg;
    logic [2:0]       nf;
    vec_pkg::vec_sew_t eew_dest;

    // Register bases and operand selects
    logic [4:0] vd_base;
    logic [4:0] vs1_base;
    logic [4:0] vs2_base;
    logic       use_imm;
    logic       use_rs1;
    logic       use_rs2;
    logic       mask_en;
    logic       reg_wen;

    // Length results
    logic [`VEC_VL_W-1:0]  eff_vl;
    logic [`VEC_UOP_W-1:0] uop_count;

    modport decoder (
        input  CLK, nRST,
        output moc, is_cfg, illegal, vset_type, vtype_imm, keep_vl,
        output mem_rd, mem_wr, unit_stride, strided, indexed, mask_ldst, whole_reg, nf,
        output eew_dest, vd_base, vs1_base, vs2_base,
        output use_imm, use_rs1, use_rs2, mask_en, reg_wen
    );

    modport evl (
        input  CLK, nRST, is_cfg, illegal, mask_ldst, whole_reg, nf, eew_dest,
        output eff_vl, uop_count
    );

    modport seq (
        input CLK, nRST, moc, is_cfg, illegal, vset_type, vtype_imm, keep_vl,
        input mem_rd, mem_wr, unit_stride, strided, indexed, mask_ldst, whole_reg, nf,
        input eew_dest, vd_base, vs1_base, vs2_base,
        input use_imm, use_rs1, use_rs2, mask_en, reg_wen, eff_vl, uop_count
    );

endinterface

// ==== design/vec_decode_top.sv ====
// Vector decode unit top: decoder, length calculator and micro-op sequencer
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_decode_top (
    input  logic                  CLK,
    input  logic                  nRST,
    // Instruction side
    input  logic [31:0]           instr,
    input  logic                  instr_req,
    input  logic [`VEC_VL_W-1:0]  vl,
    input  vec_pkg::vec_sew_t     vsew,
    output logic                  instr_ack,
    output logic                  instr_illegal,
    output vec_pkg::vec_vset_t    cfg_type,
    output logic [10:0]           vtype_imm,
    output logic                  keep_vl,
    // Micro-op side
    output logic                  uop_req,
    input  logic                  uop_ack,
    output logic [`VEC_UOP_W-1:0] uop_num,
    output logic                  uop_last,
    output logic [`VEC_VL_W-1:0]  uop_vl,
    output logic [4:0]            uop_vd,
    output logic [4:0]            uop_vs1,
    output logic [4:0]            uop_vs2,
    output vec_pkg::vec_sew_t     uop_eew,
    output logic                  uop_mem_rd,
    output logic                  uop_mem_wr,
    output logic                  uop_strided,
    output logic                  uop_indexed,
    output logic                  uop_use_imm,
    output logic                  uop_use_rs1,
    output logic                  uop_use_rs2,
    output logic                  uop_mask_en,
    output logic                  uop_reg_wen
);

    vec_decode_if dec_if (.CLK(CLK), .nRST(nRST));

    // Configuration results go straight out while instr is held
    assign instr_illegal = dec_if.illegal;
    assign cfg_type      = dec_if.vset_type;
    assign vtype_imm     = dec_if.vtype_imm;
    assign keep_vl       = dec_if.keep_vl;

    vec_instr_decode u_decode (
        .instr (instr),
        .vsew  (vsew),
        .dec   (dec_if.decoder)
    );

    vec_evl_calc u_evl (
        .vl  (vl),
        .dec (dec_if.evl)
    );

    vec_uop_seq u_seq (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_req   (instr_req),
        .instr_ack   (instr_ack),
        .uop_req     (uop_req),
        .uop_ack     (uop_ack),
        .dec         (dec_if.seq),
        .uop_num     (uop_num),
        .uop_last    (uop_last),
        .uop_vl      (uop_vl),
        .uop_vd      (uop_vd),
        .uop_vs1     (uop_vs1),
        .uop_vs2     (uop_vs2),
        .uop_eew     (uop_eew),
        .uop_mem_rd  (uop_mem_rd),
        .uop_mem_wr  (uop_mem_wr),
        .uop_strided (uop_strided),
        .uop_indexed (uop_indexed),
        .uop_use_imm (uop_use_imm),
        .uop_use_rs1 (uop_use_rs1),
        .uop_use_rs2 (uop_use_rs2),
        .uop_mask_en (uop_mask_en),
        .uop_reg_wen (uop_reg_wen)
    );

endmodule

// ==== design/vec_defines.svh ====
// Vector decode unit constants: register length, field widths and major opcodes
`ifndef VEC_DEFINES_SVH
`define VEC_DEFINES_SVH

// Vector register length in bits
`define VEC_VLEN 128

// vl and effective length, wide enough for VLEN/8 elements times eight registers
`define VEC_VL_W 8

// Largest register group that one instruction may span
`define VEC_MAX_UOPS 8

// Micro-op number and count, holds 0 to VEC_MAX_UOPS
`define VEC_UOP_W 4

// Major opcodes of the vector extension
`define VEC_OPC_LOAD 7'b0000111
`define VEC_OPC_STORE 7'b0100111
`define VEC_OPC_OPV 7'b1010111

`endif

// ==== design/vec_evl_calc.sv ====
// Effective vector length and micro-op count for the decoded instruction
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_evl_calc (
    input logic [`VEC_VL_W-1:0] vl,
    vec_decode_if.evl           dec
);

    // log2 of the element count per register at EEW 8
    localparam int LOG_EPR8 = $clog2(`VEC_VLEN / 8);

    logic [`VEC_VL_W-1:0] elems_per_reg;
    logic [`VEC_VL_W-1:0] mask_evl;
    logic [`VEC_VL_W-1:0] whole_evl;
    logic [3:0]           nregs;
    logic [`VEC_VL_W:0]   evl_round;
    logic [`VEC_VL_W:0]   raw_count;

    assign elems_per_reg = (`VEC_VLEN / 8) >> dec.eew_dest;

    // One mask bit per element, rounded up to whole bytes
    assign mask_evl = (vl >> 3) + (|vl[2:0]);

    // nf+1 full registers at the memory EEW
    assign nregs     = {1'b0, dec.nf} + 4'd1;
    assign whole_evl = nregs * elems_per_reg;

    always_comb begin
        if (dec.mask_ldst)
            dec.eff_vl = mask_evl;
        else if (dec.whole_reg)
            dec.eff_vl = whole_evl;
        else
            dec.eff_vl = vl;
    end

    // ceil(evl / elems_per_reg), one extra bit so the rounding cannot wrap
    assign evl_round = {1'b0, dec.eff_vl} + {1'b0, elems_per_reg} - 1'b1;
    assign raw_count = evl_round >> (LOG_EPR8 - int'(dec.eew_dest));

    always_comb begin
        if (dec.is_cfg || dec.illegal)
            dec.uop_count = '0;
        else if (raw_count > `VEC_MAX_UOPS)
            dec.uop_count = `VEC_UOP_W'(`VEC_MAX_UOPS);
        else
            dec.uop_count = raw_count[`VEC_UOP_W-1:0];
    end

    // vl from the core never asks for more than one register group
    a_count_fits: assert property (@(posedge dec.CLK) disable iff (!dec.nRST)
        !(dec.is_cfg || dec.illegal) |-> (raw_count <= `VEC_MAX_UOPS));

endmodule

// ==== design/vec_instr_decode.sv ====
// Vector instruction decoder: opcode class, vset* fields, memory mode and operand selects
`timescale 1ns/1ps

module vec_instr_decode (
    input  logic [31:0]       instr,
    input  vec_pkg::vec_sew_t vsew,
    vec_decode_if.decoder     dec
);

    vec_pkg::vec_instr_u iw;
    logic                is_opv;
    logic                is_fp;
    logic                is_mem;
    vec_pkg::vec_sew_t   mem_eew;

    // Both layouts overlay the same word
    assign iw = instr;

    // Major opcode class
    always_comb begin
        case (iw.alu.opcode)
            vec_pkg::OPC_LOAD:  dec.moc = vec_pkg::MOC_LOAD;
            vec_pkg::OPC_STORE: dec.moc = vec_pkg::MOC_STORE;
            vec_pkg::OPC_OPV:   dec.moc = vec_pkg::MOC_ALU_CFG;
            default:            dec.moc = vec_pkg::MOC_INVALID;
        endcase
    end

    assign is_opv     = (dec.moc == vec_pkg::MOC_ALU_CFG);
    assign dec.mem_rd = (dec.moc == vec_pkg::MOC_LOAD);
    assign dec.mem_wr = (dec.moc == vec_pkg::MOC_STORE);
    assign is_mem     = dec.mem_rd || dec.mem_wr;
    assign dec.is_cfg = is_opv && (iw.alu.funct3 == vec_pkg::OPCFG);

    // No floating-point unit behind this decoder
    assign is_fp = is_opv && (iw.alu.funct3 == vec_pkg::OPFVV ||
                              iw.alu.funct3 == vec_pkg::OPFVF);
    assign dec.illegal = (dec.moc == vec_pkg::MOC_INVALID) || is_fp;

    // vset* form from bits 31:30, immediate taken from bits 30:20 or 29:20
    always_comb begin
        dec.vset_type = vec_pkg::NOT_CFG;
        dec.vtype_imm = '0;
        dec.keep_vl   = 1'b0;
        if (dec.is_cfg) begin
            casez (iw.alu.funct6[5:4])
                2'b0?: begin
                    dec.vset_type = vec_pkg::VSETVLI;
                    dec.vtype_imm = {iw.alu.funct6[4:0], iw.alu.vm, iw.alu.vs2};
                end
                2'b11: begin
                    dec.vset_type = vec_pkg::VSETIVLI;
                    dec.vtype_imm = {1'b0, iw.alu.funct6[3:0], iw.alu.vm, iw.alu.vs2};
                end
                default: dec.vset_type = vec_pkg::VSETVL;
            endcase
            // rs1 = x0 and rd = x0 keeps the current vl, not for the immediate form
            dec.keep_vl = (dec.vset_type != vec_pkg::VSETIVLI) &&
                          (iw.alu.vs1 == '0) && (iw.alu.vd == '0);
        end
    end

    // Addressing mode
    assign dec.unit_stride = is_mem && (iw.mem.mop == vec_pkg::MOP_UNIT);
    assign dec.strided     = is_mem && (iw.mem.mop == vec_pkg::MOP_STRIDED);
    assign dec.indexed     = is_mem && (iw.mem.mop == vec_pkg::MOP_UINDEXED ||
                                        iw.mem.mop == vec_pkg::MOP_OINDEXED);
    assign dec.mask_ldst   = dec.unit_stride && (iw.mem.lumop_rs2 == vec_pkg::LUMOP_MASK);
    assign dec.whole_reg   = dec.unit_stride && (iw.mem.lumop_rs2 == vec_pkg::LUMOP_FULLREG);
    assign dec.nf          = iw.mem.nf;

    always_comb begin
        case (iw.mem.width)
            vec_pkg::WIDTH8:  mem_eew = vec_pkg::SEW8;
            vec_pkg::WIDTH16: mem_eew = vec_pkg::SEW16;
            default:          mem_eew = vec_pkg::SEW32;
        endcase
    end

    // Indexed data follows vsew, the width field then sizes only the index
    always_comb begin
        dec.eew_dest = vsew;
        if (dec.mask_ldst)
            dec.eew_dest = vec_pkg::SEW8;
        else if (is_mem && !dec.indexed)
            dec.eew_dest = mem_eew;
    end

    // Register bases, a store reads its data from vs3 in the vd slot
    assign dec.vd_base  = iw.alu.vd;
    assign dec.vs1_base = dec.mem_wr ? iw.mem.vd : iw.alu.vs1;
    assign dec.vs2_base = iw.alu.vs2;

    // Operand selects
    assign dec.use_imm = is_opv && (iw.alu.funct3 == vec_pkg::OPIVI);
    assign dec.use_rs1 = is_mem || (is_opv && (iw.alu.funct3 == vec_pkg::OPIVX ||
                                               iw.alu.funct3 == vec_pkg::OPFVF ||
                                               iw.alu.funct3 == vec_pkg::OPMVX));
    // Stride or plain base, an index register takes the rs2 slot otherwise
    assign dec.use_rs2 = is_mem && !dec.indexed;
    assign dec.mask_en = !iw.alu.vm && !dec.is_cfg;
    assign dec.reg_wen = !dec.mem_wr && !dec.is_cfg;

    // Every word lands in exactly one class
    a_one_class: assert property (@(posedge dec.CLK) disable iff (!dec.nRST)
        $onehot({dec.is_cfg, dec.illegal, dec.mem_rd, dec.mem_wr,
                 (dec.moc == vec_pkg::MOC_ALU_CFG) && !dec.is_cfg && !dec.illegal}));

endmodule

// ==== design/vec_pkg.sv ====
// Vector decode types: field enums and the two views of an instruction word
`include "vec_defines.svh"

package vec_pkg;

    // Major opcode field values
    typedef enum logic [6:0] {
        OPC_LOAD  = `VEC_OPC_LOAD,
        OPC_STORE = `VEC_OPC_STORE,
        OPC_OPV   = `VEC_OPC_OPV
    } vec_opc_t;

    // Major opcode class after decode
    typedef enum logic [1:0] {MOC_LOAD, MOC_STORE, MOC_ALU_CFG, MOC_INVALID} vec_moc_t;

    // Arithmetic format, funct3 of the OP-V opcode
    typedef enum logic [2:0] {
        OPIVV, OPFVV, OPMVV, OPIVI, OPIVX, OPFVF, OPMVX, OPCFG
    } vec_funct3_t;

    // Memory addressing mode
    typedef enum logic [1:0] {MOP_UNIT, MOP_UINDEXED, MOP_STRIDED, MOP_OINDEXED} vec_mop_t;

    // Unit-stride sub-modes that change the access size
    typedef enum logic [4:0] {
        LUMOP_UNIT    = 5'b00000,
        LUMOP_FULLREG = 5'b01000,
        LUMOP_MASK    = 5'b01011
    } vec_lumop_t;

    // Memory element width field
    typedef enum logic [2:0] {
        WIDTH8  = 3'b000,
        WIDTH16 = 3'b101,
        WIDTH32 = 3'b110
    } vec_width_t;

    typedef enum logic [1:0] {SEW8, SEW16, SEW32} vec_sew_t;

    typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} vec_vset_t;

    // Load/store layout, lumop_rs2 holds rs2 for strided accesses
    typedef struct packed {
        logic [2:0] nf;
        logic       mew;
        vec_mop_t   mop;
        logic       vm;
        logic [4:0] lumop_rs2;
        logic [4:0] rs1;
        vec_width_t width;
        logic [4:0] vd;
        vec_opc_t   opcode;
    } vec_mem_fmt_t;

    // Arithmetic and vset* layout
    typedef struct packed {
        logic [5:0]  funct6;
        logic        vm;
        logic [4:0]  vs2;
        logic [4:0]  vs1;
        vec_funct3_t funct3;
        logic [4:0]  vd;
        vec_opc_t    opcode;
    } vec_alu_fmt_t;

    typedef union packed {
        vec_mem_fmt_t mem;
        vec_alu_fmt_t alu;
    } vec_instr_u;

endpackage

// ==== design/vec_uop_seq.sv ====
// Micro-op sequencer: instruction and micro-op four-phase handshakes with issue counter
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_uop_seq (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  instr_req,
    output logic                  instr_ack,
    output logic                  uop_req,
    input  logic                  uop_ack,
    vec_decode_if.seq             dec,
    output logic [`VEC_UOP_W-1:0] uop_num,
    output logic                  uop_last,
    output logic [`VEC_VL_W-1:0]  uop_vl,
    output logic [4:0]            uop_vd,
    output logic [4:0]            uop_vs1,
    output logic [4:0]            uop_vs2,
    output vec_pkg::vec_sew_t     uop_eew,
    output logic                  uop_mem_rd,
    output logic                  uop_mem_wr,
    output logic                  uop_strided,
    output logic                  uop_indexed,
    output logic                  uop_use_imm,
    output logic                  uop_use_rs1,
    output logic                  uop_use_rs2,
    output logic                  uop_mask_en,
    output logic                  uop_reg_wen
);

    typedef enum logic [1:0] {IDLE, ISSUE, RELEASE, DONE} seq_state_t;

    seq_state_t            state, state_nxt;
    logic [`VEC_UOP_W-1:0] cnt, cnt_nxt;
    logic [`VEC_VL_W-1:0]  elems_per_reg;
    logic [`VEC_VL_W-1:0]  consumed;
    logic [`VEC_VL_W-1:0]  remaining;

    // ISSUE holds uop_req, DONE holds instr_ack
    assign uop_req   = (state == ISSUE);
    assign instr_ack = (state == DONE);

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        case (state)
            IDLE: begin
                if (instr_req) begin
                    cnt_nxt = '0;
                    // vset*, illegal and empty instructions answer at once
                    state_nxt = (dec.uop_count == '0) ? DONE : ISSUE;
                end
            end
            ISSUE: begin
                if (uop_ack)
                    state_nxt = RELEASE;
            end
            RELEASE: begin
                // Wait for the consumer to close the handshake
                if (!uop_ack) begin
                    if (uop_last) begin
                        state_nxt = DONE;
                    end else begin
                        cnt_nxt   = cnt + 1'b1;
                        state_nxt = ISSUE;
                    end
                end
            end
            default: begin
                if (!instr_req)
                    state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
        end
    end

    // Element split, the last register takes whatever is left of evl
    assign elems_per_reg = (`VEC_VLEN / 8) >> dec.eew_dest;
    assign consumed      = `VEC_VL_W'(cnt) * elems_per_reg;
    assign remaining     = dec.eff_vl - consumed;

    assign uop_num  = cnt;
    assign uop_last = (cnt == dec.uop_count - 1'b1);
    assign uop_vl   = (remaining < elems_per_reg) ? remaining : elems_per_reg;

    // All three register fields step together
    assign uop_vd  = dec.vd_base + 5'(cnt);
    assign uop_vs1 = dec.vs1_base + 5'(cnt);
    assign uop_vs2 = dec.vs2_base + 5'(cnt);

    assign uop_eew     = dec.eew_dest;
    assign uop_mem_rd  = dec.mem_rd;
    assign uop_mem_wr  = dec.mem_wr;
    assign uop_strided = dec.strided;
    assign uop_indexed = dec.indexed;
    assign uop_use_imm = dec.use_imm;
    assign uop_use_rs1 = dec.use_rs1;
    assign uop_use_rs2 = dec.use_rs2;
    assign uop_mask_en = dec.mask_en;
    assign uop_reg_wen = dec.reg_wen;

    // Fields hold until the consumer has seen them
    a_uop_stable: assert property (@(posedge CLK) disable iff (!nRST)
        uop_req && !uop_ack |=> $stable({uop_num, uop_last, uop_vl, uop_vd, uop_vs1,
                                          uop_vs2, uop_eew, uop_mem_rd, uop_mem_wr,
                                          uop_strided, uop_indexed, uop_use_imm,
                                          uop_use_rs1, uop_use_rs2, uop_mask_en,
                                          uop_reg_wen}));

    a_ack_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(instr_ack && uop_req));

endmodule

// ==== dv/tb_vec_decode.sv ====
// Directed testbench for the vector decode unit: vset*, arithmetic, memory and illegal words
`timescale 1ns/1ps
`include "vec_defines.svh"

module tb_vec_decode;

    // Bound on instructions sent, each allowed a full register group of handshakes
    localparam int MAX_INSTR   = 40;
    localparam int UOP_CYCLES  = 6;
    localparam int WATCHDOG_NS = (8 + MAX_INSTR * `VEC_MAX_UOPS * UOP_CYCLES) * 4;

    logic                  CLK;
    logic                  nRST;
    logic [31:0]           instr;
    logic                  instr_req;
    logic [`VEC_VL_W-1:0]  vl;
    vec_pkg::vec_sew_t     vsew;
    logic                  instr_ack;
    logic                  instr_illegal;
    vec_pkg::vec_vset_t    cfg_type;
    logic [10:0]           vtype_imm;
    logic                  keep_vl;
    logic                  uop_req;
    logic                  uop_ack;
    logic [`VEC_UOP_W-1:0] uop_num;
    logic                  uop_last;
    logic [`VEC_VL_W-1:0]  uop_vl;
    logic [4:0]            uop_vd, uop_vs1, uop_vs2;
    vec_pkg::vec_sew_t     uop_eew;
    logic                  uop_mem_rd, uop_mem_wr, uop_strided, uop_indexed;
    logic                  uop_use_imm, uop_use_rs1, uop_use_rs2, uop_mask_en, uop_reg_wen;

    int          checks = 0;
    int          errors = 0;
    logic [15:0] lfsr = 16'd46;

    // Expected response of the instruction in flight
    int exp_count, exp_evl, exp_epr, exp_eew;
    int exp_vd, exp_vs1, exp_vs2;
    int exp_mem_rd, exp_mem_wr, exp_strided, exp_indexed;
    int exp_use_imm, exp_use_rs1, exp_use_rs2, exp_mask_en, exp_reg_wen;
    int exp_illegal, exp_cfg_type, exp_vtype_imm, exp_keep_vl;

    vec_decode_top UUT (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic logic [31:0] opv_encode(input logic [5:0] funct6, input logic vm,
                                               input logic [4:0] vs2, input logic [4:0] vs1,
                                               input vec_pkg::vec_funct3_t f3,
                                               input logic [4:0] vd);
        return {funct6, vm, vs2, vs1, f3, vd, vec_pkg::OPC_OPV};
    endfunction

    function automatic logic [31:0] mem_encode(input logic store, input logic [2:0] nf,
                                               input vec_pkg::vec_mop_t mop, input logic vm,
                                               input logic [4:0] lumop_rs2,
                                               input logic [4:0] rs1,
                                               input vec_pkg::vec_width_t width,
                                               input logic [4:0] vd);
        vec_pkg::vec_opc_t opc;
        if (store)
            opc = vec_pkg::OPC_STORE;
        else
            opc = vec_pkg::OPC_LOAD;
        // mew stays 0, no 64-bit and wider elements here
        return {nf, 1'b0, mop, vm, lumop_rs2, rs1, width, vd, opc};
    endfunction

    // 0, 1, 2 select 8, 16, 32 bit memory elements
    function automatic vec_pkg::vec_width_t width_field(input int wsel);
        case (wsel)
            0:       return vec_pkg::WIDTH8;
            1:       return vec_pkg::WIDTH16;
            default: return vec_pkg::WIDTH32;
        endcase
    endfunction

    task automatic compare(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, want);
        end
    endtask

    // No micro-ops, no flags, not a vset*
    task automatic clear_expect();
        exp_count = 0;
        exp_evl = 0;
        exp_epr = 16;
        exp_eew = 0;
        {exp_vd, exp_vs1, exp_vs2} = '0;
        {exp_mem_rd, exp_mem_wr, exp_strided, exp_indexed} = '0;
        {exp_use_imm, exp_use_rs1, exp_use_rs2, exp_mask_en, exp_reg_wen} = '0;
        exp_illegal   = 0;
        exp_cfg_type  = int'(vec_pkg::NOT_CFG);
        exp_vtype_imm = 0;
        exp_keep_vl   = 0;
    endtask

    // Register group split: VLEN/EEW elements per register, count rounded up
    task automatic split_expect(input int evl, input int eew);
        exp_evl   = evl;
        exp_eew   = eew;
        exp_epr   = `VEC_VLEN / (8 << eew);
        exp_count = (evl + exp_epr - 1) / exp_epr;
        if (exp_count > `VEC_MAX_UOPS)
            exp_count = `VEC_MAX_UOPS;
    endtask

    task automatic check_uop(input int n);
        int rem;
        int want_vl;
        rem     = exp_evl - n * exp_epr;
        want_vl = (rem < exp_epr) ? rem : exp_epr;
        compare("uop_num", int'(uop_num), n);
        compare("uop_last", int'(uop_last), int'(n == exp_count - 1));
        compare("uop_vl", int'(uop_vl), want_vl);
        // All three fields step by the same register offset
        compare("uop_vd", int'(uop_vd), (exp_vd + n) % 32);
        compare("uop_vs1", int'(uop_vs1), (exp_vs1 + n) % 32);
        compare("uop_vs2", int'(uop_vs2), (exp_vs2 + n) % 32);
        compare("uop_eew", int'(uop_eew), exp_eew);
        compare("uop_mem_rd", int'(uop_mem_rd), exp_mem_rd);
        compare("uop_mem_wr", int'(uop_mem_wr), exp_mem_wr);
        compare("uop_strided", int'(uop_strided), exp_strided);
        compare("uop_indexed", int'(uop_indexed), exp_indexed);
        compare("uop_use_imm", int'(uop_use_imm), exp_use_imm);
        compare("uop_use_rs1", int'(uop_use_rs1), exp_use_rs1);
        compare("uop_use_rs2", int'(uop_use_rs2), exp_use_rs2);
        compare("uop_mask_en", int'(uop_mask_en), exp_mask_en);
        compare("uop_reg_wen", int'(uop_reg_wen), exp_reg_wen);
    endtask

    // Full instruction handshake, consumer side answers every micro-op
    task automatic run_instr(input logic [31:0] word, input int vl_in, input int sew);
        int n;
        int stall;
        n = 0;
        @(negedge CLK);
        instr     = word;
        vl        = `VEC_VL_W'(vl_in);
        vsew      = vec_pkg::vec_sew_t'(sew);
        instr_req = 1'b1;
        while (!instr_ack) begin
            @(negedge CLK);
            if (uop_req && !uop_ack) begin
                checks++;
                assert (n < exp_count) else begin
                    errors++;
                    $display("Micro-op %0d issued at %0t ns, only %0d expected",
                             n, $time, exp_count);
                end
                if (n < exp_count)
                    check_uop(n);
                n++;
                // Consumer sometimes holds off its answer for a cycle
                take_bits(1, stall);
                if (stall != 0) begin
                    @(negedge CLK);
                    compare("uop_req under back-pressure", int'(uop_req), 1);
                end
                uop_ack = 1'b1;
            end else if (!uop_req && uop_ack) begin
                uop_ack = 1'b0;
            end
        end
        // Decode outputs are valid while instr_ack is high
        compare("micro-op count", n, exp_count);
        compare("instr_illegal", int'(instr_illegal), exp_illegal);
        compare("cfg_type", int'(cfg_type), exp_cfg_type);
        compare("vtype_imm", int'(vtype_imm), exp_vtype_imm);
        compare("keep_vl", int'(keep_vl), exp_keep_vl);
        @(negedge CLK);
        instr_req = 1'b0;
        while (instr_ack)
            @(negedge CLK);
    endtask

    task automatic reset_state_check();
        compare("instr_ack", int'(instr_ack), 0);
        compare("uop_req", int'(uop_req), 0);
    endtask

    task automatic vset_decode();
        int imm;
        int rs;
        // vsetvli with rs1 = rd = x0 keeps vl
        take_bits(11, imm);
        clear_expect();
        exp_cfg_type  = int'(vec_pkg::VSETVLI);
        exp_vtype_imm = imm;
        exp_keep_vl   = 1;
        run_instr(opv_encode({1'b0, imm[10:6]}, imm[5], imm[4:0], 5'd0,
                             vec_pkg::OPCFG, 5'd0), 0, 0);
        // Nonzero rs1 asks for a new vl
        take_bits(11, imm);
        take_bits(5, rs);
        rs = rs | 1;
        exp_vtype_imm = imm;
        exp_keep_vl   = 0;
        run_instr(opv_encode({1'b0, imm[10:6]}, imm[5], imm[4:0], rs[4:0],
                             vec_pkg::OPCFG, 5'd3), 0, 0);
        // vsetivli never keeps vl, 10-bit immediate
        take_bits(10, imm);
        exp_cfg_type  = int'(vec_pkg::VSETIVLI);
        exp_vtype_imm = imm;
        run_instr(opv_encode({2'b11, imm[9:6]}, imm[5], imm[4:0], 5'd0,
                             vec_pkg::OPCFG, 5'd0), 0, 0);
        // vsetvl takes vtype from rs2, no immediate
        take_bits(5, rs);
        exp_cfg_type  = int'(vec_pkg::VSETVL);
        exp_vtype_imm = 0;
        exp_keep_vl   = 1;
        run_instr(opv_encode(6'b100000, 1'b0, rs[4:0], 5'd0, vec_pkg::OPCFG, 5'd0), 0, 0);
    endtask

    task automatic arith_split();
        vec_pkg::vec_funct3_t fmts [5] = '{vec_pkg::OPIVV, vec_pkg::OPIVI, vec_pkg::OPIVX,
                                           vec_pkg::OPMVV, vec_pkg::OPMVX};
        int sew, vlv, r, vd, vs1, vs2, vm, f6;
        for (int f = 0; f < 5; f++) begin
            for (int rep = 0; rep < 3; rep++) begin
                take_bits(2, r);
                sew = r % 3;
                take_bits(8, r);
                // Stay within one group of eight registers
                vlv = r % (8 * (`VEC_VLEN / (8 << sew))) + 1;
                take_bits(5, vd);
                take_bits(5, vs1);
                take_bits(5, vs2);
                take_bits(1, vm);
                take_bits(6, f6);
                clear_expect();
                split_expect(vlv, sew);
                exp_vd      = vd;
                exp_vs1     = vs1;
                exp_vs2     = vs2;
                exp_use_imm = int'(fmts[f] == vec_pkg::OPIVI);
                exp_use_rs1 = int'(fmts[f] == vec_pkg::OPIVX || fmts[f] == vec_pkg::OPMVX);
                exp_mask_en = int'(vm == 0);
                exp_reg_wen = 1;
                run_instr(opv_encode(f6[5:0], vm[0], vs2[4:0], vs1[4:0], fmts[f], vd[4:0]),
                          vlv, sew);
            end
        end
    endtask

    task automatic mem_access();
        int wsel, sew, eew, vlv, r, vd, rs1, rs2, vm, idx;
        for (int st = 0; st < 2; st++) begin
            // mop 0 unit, 1 unordered indexed, 2 strided, 3 ordered indexed
            for (int m = 0; m < 4; m++) begin
                idx = int'(m == 1 || m == 3);
                take_bits(2, r);
                wsel = r % 3;
                take_bits(2, r);
                sew = r % 3;
                // Indexed data takes vsew, the rest the width field
                eew = idx ? sew : wsel;
                take_bits(8, r);
                vlv = r % (8 * (`VEC_VLEN / (8 << eew))) + 1;
                take_bits(5, vd);
                take_bits(5, rs1);
                take_bits(5, rs2);
                take_bits(1, vm);
                // Plain unit stride keeps lumop at zero
                if (m == 0)
                    rs2 = 0;
                clear_expect();
                split_expect(vlv, eew);
                exp_vd      = vd;
                exp_vs1     = st ? vd : rs1;
                exp_vs2     = rs2;
                exp_mem_rd  = int'(st == 0);
                exp_mem_wr  = st;
                exp_strided = int'(m == 2);
                exp_indexed = idx;
                exp_use_rs1 = 1;
                exp_use_rs2 = int'(idx == 0);
                exp_mask_en = int'(vm == 0);
                exp_reg_wen = int'(st == 0);
                run_instr(mem_encode(st[0], 3'd0, vec_pkg::vec_mop_t'(m[1:0]), vm[0],
                                     rs2[4:0], rs1[4:0], width_field(wsel), vd[4:0]),
                          vlv, sew);
            end
        end
    endtask

    task automatic mask_whole_access();
        int r, vlv, sew, nf, wsel, vd;
        // Mask loads move ceil(vl/8) bytes
        for (int rep = 0; rep < 2; rep++) begin
            take_bits(8, vlv);
            take_bits(2, r);
            sew = r % 3;
            take_bits(5, vd);
            clear_expect();
            split_expect((vlv + 7) / 8, 0);
            exp_vd      = vd;
            exp_vs1     = 5;
            exp_vs2     = int'(vec_pkg::LUMOP_MASK);
            exp_mem_rd  = 1;
            exp_use_rs1 = 1;
            exp_use_rs2 = 1;
            exp_reg_wen = 1;
            run_instr(mem_encode(1'b0, 3'd0, vec_pkg::MOP_UNIT, 1'b1, vec_pkg::LUMOP_MASK,
                                 5'd5, vec_pkg::WIDTH8, vd[4:0]), vlv, sew);
        end
        // Whole-register loads ignore vl and fill nf+1 registers
        for (int rep = 0; rep < 3; rep++) begin
            take_bits(3, nf);
            take_bits(2, r);
            wsel = r % 3;
            take_bits(8, vlv);
            clear_expect();
            split_expect((nf + 1) * (`VEC_VLEN / (8 << wsel)), wsel);
            exp_vd      = 8;
            exp_vs1     = 2;
            exp_vs2     = int'(vec_pkg::LUMOP_FULLREG);
            exp_mem_rd  = 1;
            exp_use_rs1 = 1;
            exp_use_rs2 = 1;
            exp_reg_wen = 1;
            run_instr(mem_encode(1'b0, nf[2:0], vec_pkg::MOP_UNIT, 1'b1,
                                 vec_pkg::LUMOP_FULLREG, 5'd2, width_field(wsel), 5'd8),
                      vlv, 0);
        end
    endtask

    task automatic illegal_reject();
        clear_expect();
        exp_illegal = 1;
        // Scalar add, not a vector opcode
        run_instr(32'h00b50533, 16, 0);
        run_instr(opv_encode(6'b000000, 1'b1, 5'd4, 5'd6, vec_pkg::OPFVV, 5'd2), 16, 0);
    endtask

    initial begin
        instr     = '0;
        instr_req = 1'b0;
        vl        = '0;
        vsew      = vec_pkg::SEW8;
        uop_ack   = 1'b0;
        nRST      = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        reset_state_check();
        vset_decode();
        arith_split();
        mem_access();
        mask_whole_access();
        illegal_reject();
        @(negedge CLK);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Ends a run in which a handshake never closes
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, a handshake never completed", WATCHDOG_NS);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
